// File: project.f
design/warp_sched_pkg.sv
design/warp_table.sv
design/barrier_unit.sv
design/issue_stage.sv
design/warp_scheduler.sv
dv/tb_warp_scheduler.sv

// File: Makefile
SIM = obj_dir/Vtb_warp_scheduler
SRCS = $(shell cat project.f)

.PHONY: all run clean

all: run

$(SIM): project.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_warp_scheduler -f project.f

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

// File: dv/tb_warp_scheduler.sv
// directed scheduler tests under random back-pressure; stimulus relies on each drain finishing first
`timescale 1ns/1ps

module tb_warp_scheduler import warp_sched_pkg::*; ();

    localparam pc_t start_pc = 32'h0000_1000;
    // the tests take about 400 cycles, so this leaves a wide margin
    localparam int timeout_cycles = 2000;

    logic        clk = 1'b0;
    logic        reset;
    pc_t         startup_pc;
    logic        warp_ctl_valid;
    warp_ctl_t   warp_ctl;
    logic        branch_valid;
    branch_t     branch;
    logic        unlock_valid;
    wid_t        unlock_wid;
    bar_id_t     bar_rd_id;
    logic        sched_valid;
    logic        sched_ready = 1'b0;
    sched_item_t sched_item;
    gen_t        arrive_token;
    logic        busy;

    // scoreboard owned by the stimulus process
    sched_item_t exp_q [$];
    sched_item_t exp_head;
    logic        exp_avail;
    pc_t         m_pc [num_warps];
    tmask_t      m_tmask [num_warps];
    gen_t        exp_token;
    logic        exp_busy;

    sched_item_t prev_item = '0;
    logic        prev_stall = 1'b0;
    logic [31:0] lfsr_state = 32'hc0b98a7b;
    int          cycle_count = 0;

    warp_scheduler dut (
        .clk            (clk),
        .reset          (reset),
        .startup_pc     (startup_pc),
        .warp_ctl_valid (warp_ctl_valid),
        .warp_ctl       (warp_ctl),
        .branch_valid   (branch_valid),
        .branch         (branch),
        .unlock_valid   (unlock_valid),
        .unlock_wid     (unlock_wid),
        .bar_rd_id      (bar_rd_id),
        .sched_valid    (sched_valid),
        .sched_ready    (sched_ready),
        .sched_item     (sched_item),
        .arrive_token   (arrive_token),
        .busy           (busy)
    );

    always #20 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    // one ready bit per cycle
    always @(posedge clk) begin
        #1;
        lfsr_state  = lfsr_step(lfsr_state);
        sched_ready = lfsr_state[0];
    end

    always @(posedge clk) begin
        prev_item  <= sched_item;
        prev_stall <= sched_valid && !sched_ready;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            report_failure($sformatf("timeout after %0d cycles waiting for expected items",
                cycle_count));
        end
    end

    item_expected: assert property (@(posedge clk) disable iff (reset)
        (sched_valid && sched_ready) |-> exp_avail)
        else report_failure($sformatf("an item was transferred at %0t with none expected", $time));

    item_matches: assert property (@(posedge clk) disable iff (reset)
        (sched_valid && sched_ready && exp_avail) |-> (sched_item == exp_head))
        else report_failure($sformatf("error at %0t: sched_item expected %h got %h",
            $time, $sampled(exp_head), $sampled(sched_item)));

    item_held: assert property (@(posedge clk) disable iff (reset)
        prev_stall |-> (sched_valid && sched_item == prev_item))
        else report_failure($sformatf("error at %0t: sched_item expected %h got %h while held",
            $time, $sampled(prev_item), $sampled(sched_item)));

    token_matches: assert property (@(posedge clk) disable iff (reset)
        arrive_token == exp_token)
        else report_failure($sformatf("error at %0t: arrive_token expected %0d got %0d",
            $time, $sampled(exp_token), $sampled(arrive_token)));

    busy_matches: assert property (@(posedge clk) disable iff (reset)
        busy == exp_busy)
        else report_failure($sformatf("error at %0t: busy expected %0b got %0b",
            $time, $sampled(exp_busy), $sampled(busy)));

    // outputs and ready are settled at the falling edge
    task automatic next_cycle();
        @(negedge clk);
        exp_avail = (exp_q.size() > 0);
        if (exp_avail && !reset && sched_valid && sched_ready) begin
            // leaves at the coming rising edge
            exp_head = exp_q.pop_front();
            m_pc[exp_head.wid] = exp_head.pc + pc_t'(4);
        end else if (exp_avail) begin
            exp_head = exp_q[0];
        end
        @(posedge clk);
        #1;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) next_cycle();
    endtask

    task automatic expect_item(input wid_t w);
        sched_item_t item;
        item.wid   = w;
        item.tmask = m_tmask[w];
        item.pc    = m_pc[w];
        exp_q.push_back(item);
    endtask

    // quiet spell afterwards so stray items show up here
    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            next_cycle();
        end
        idle(8);
    endtask

    task automatic unlock_warp(input wid_t w);
        unlock_valid = 1'b1;
        unlock_wid   = w;
        next_cycle();
        unlock_valid = 1'b0;
    endtask

    task automatic branch_warp(input wid_t w, input logic taken, input pc_t dest);
        branch_valid = 1'b1;
        branch.wid   = w;
        branch.taken = taken;
        branch.dest  = dest;
        next_cycle();
        branch_valid = 1'b0;
    endtask

    task automatic drive_ctl(input warp_ctl_t ctl);
        warp_ctl_valid = 1'b1;
        warp_ctl       = ctl;
        next_cycle();
        warp_ctl_valid = 1'b0;
        warp_ctl       = '0;
    endtask

    task automatic spawn_warps(input wid_t w, input warp_mask_t wmask, input pc_t pc);
        warp_ctl_t ctl;
        ctl                    = '0;
        ctl.wid                = w;
        ctl.wspawn.spawn_valid = 1'b1;
        ctl.wspawn.wmask       = wmask;
        ctl.wspawn.pc          = pc;
        drive_ctl(ctl);
    endtask

    task automatic set_tmask(input wid_t w, input tmask_t tmask);
        warp_ctl_t ctl;
        ctl               = '0;
        ctl.wid           = w;
        ctl.tmc.tmc_valid = 1'b1;
        ctl.tmc.tmask     = tmask;
        m_tmask[w]        = tmask;
        drive_ctl(ctl);
    endtask

    task automatic barrier_op(input wid_t w, input bar_op_e op, input logic sync,
                              input bar_id_t id, input wid_t count, input gen_t token);
        warp_ctl_t ctl;
        ctl                   = '0;
        ctl.wid               = w;
        ctl.barrier.bar_valid = 1'b1;
        ctl.barrier.op        = op;
        ctl.barrier.is_sync   = sync;
        ctl.barrier.id        = id;
        ctl.barrier.count     = count;
        ctl.barrier.token     = token;
        drive_ctl(ctl);
    endtask

    initial begin
        reset          = 1'b1;
        startup_pc     = start_pc;
        warp_ctl_valid = 1'b0;
        warp_ctl       = '0;
        branch_valid   = 1'b0;
        branch         = '0;
        unlock_valid   = 1'b0;
        unlock_wid     = '0;
        bar_rd_id      = '0;
        exp_avail      = 1'b0;
        exp_head       = '0;
        exp_token      = '0;
        exp_busy       = 1'b1;
        for (int w = 0; w < num_warps; w++) begin
            m_pc[w]    = '0;
            m_tmask[w] = '0;
        end
        m_pc[0]    = start_pc;
        m_tmask[0] = tmask_t'(1);
        expect_item(2'd0);
        // the first rising edge comes before the first falling one
        idle(1);
        reset = 1'b0;

        // startup item, then pc + 4 after decode unlock
        wait_drain();
        expect_item(2'd0);
        unlock_warp(2'd0);
        wait_drain();

        // taken branch moves the pc, not taken only unlocks
        m_pc[0] = 32'h0000_2000;
        expect_item(2'd0);
        branch_warp(2'd0, 1'b1, 32'h0000_2000);
        wait_drain();
        expect_item(2'd0);
        branch_warp(2'd0, 1'b0, 32'hdead_beec);
        wait_drain();

        // warp 0 runs alone, so the spawn applies at once
        for (int w = 1; w < num_warps; w++) begin
            m_pc[w]    = 32'h0000_3000;
            m_tmask[w] = tmask_t'(1);
        end
        for (int w = 0; w < num_warps; w++) begin
            expect_item(wid_t'(w));
        end
        spawn_warps(2'd0, 4'b1110, 32'h0000_3000);
        wait_drain();

        // sync barrier 1 for three warps
        bar_rd_id = 2'd1;
        exp_token = 8'd0;
        barrier_op(2'd1, bar_arrive, 1'b1, 2'd1, 2'd2, 8'd0);
        barrier_op(2'd2, bar_arrive, 1'b1, 2'd1, 2'd2, 8'd0);
        idle(8);
        expect_item(2'd1);
        expect_item(2'd2);
        expect_item(2'd3);
        barrier_op(2'd3, bar_arrive, 1'b1, 2'd1, 2'd2, 8'd0);
        exp_token = 8'd1;
        wait_drain();

        // older token passes straight through
        expect_item(2'd1);
        barrier_op(2'd1, bar_wait, 1'b0, 2'd1, 2'd1, 8'd0);
        wait_drain();
        // current token parks warp 1 until the barrier completes
        barrier_op(2'd1, bar_wait, 1'b0, 2'd1, 2'd1, 8'd1);
        idle(8);
        expect_item(2'd2);
        barrier_op(2'd2, bar_arrive, 1'b0, 2'd1, 2'd1, 8'd0);
        wait_drain();
        expect_item(2'd1);
        expect_item(2'd3);
        barrier_op(2'd3, bar_arrive, 1'b0, 2'd1, 2'd1, 8'd0);
        exp_token = 8'd2;
        wait_drain();

        // ascending unlocks keep the issue order fixed whatever ready does
        for (int round = 0; round < 8; round++) begin
            for (int w = 0; w < num_warps; w++) begin
                expect_item(wid_t'(w));
                unlock_warp(wid_t'(w));
            end
            wait_drain();
        end

        // empty masks retire every warp, busy follows a cycle later
        for (int w = 0; w < num_warps; w++) begin
            set_tmask(wid_t'(w), 4'b0000);
        end
        next_cycle();
        exp_busy = 1'b0;
        unlock_warp(2'd0);
        wait_drain();

        $display("Done: no errors");
        $finish;
    end

endmodule

// File: design/warp_scheduler.sv
// single branch port, local barriers only; busy reflects active warps, not in-flight instructions
`timescale 1ns/1ps

module warp_scheduler import warp_sched_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  pc_t         startup_pc,
    input  logic        warp_ctl_valid,
    input  warp_ctl_t   warp_ctl,
    input  logic        branch_valid,
    input  branch_t     branch,
    input  logic        unlock_valid,
    input  wid_t        unlock_wid,
    input  bar_id_t     bar_rd_id,
    output logic        sched_valid,
    input  logic        sched_ready,
    output sched_item_t sched_item,
    output gen_t        arrive_token,
    output logic        busy
);

    warp_mask_t             ready_warps;
    tmask_t [num_warps-1:0] warp_tmasks;
    pc_t [num_warps-1:0]    warp_pcs;
    warp_mask_t             bar_release;
    logic                   select_fire;
    wid_t                   select_wid;
    logic                   out_fire;
    sched_item_t            out_item;

    warp_table u_warp_table (
        .clk            (clk),
        .reset          (reset),
        .startup_pc     (startup_pc),
        .warp_ctl_valid (warp_ctl_valid),
        .warp_ctl       (warp_ctl),
        .branch_valid   (branch_valid),
        .branch         (branch),
        .unlock_valid   (unlock_valid),
        .unlock_wid     (unlock_wid),
        .bar_release    (bar_release),
        .select_fire    (select_fire),
        .select_wid     (select_wid),
        .out_fire       (out_fire),
        .out_item       (out_item),
        .ready_warps    (ready_warps),
        .warp_tmasks    (warp_tmasks),
        .warp_pcs       (warp_pcs),
        .busy           (busy)
    );

    barrier_unit u_barrier_unit (
        .clk            (clk),
        .reset          (reset),
        .warp_ctl_valid (warp_ctl_valid),
        .warp_ctl       (warp_ctl),
        .bar_rd_id      (bar_rd_id),
        .arrive_token   (arrive_token),
        .bar_release    (bar_release)
    );

    issue_stage u_issue_stage (
        .clk         (clk),
        .reset       (reset),
        .ready_warps (ready_warps),
        .warp_tmasks (warp_tmasks),
        .warp_pcs    (warp_pcs),
        .select_fire (select_fire),
        .select_wid  (select_wid),
        .out_fire    (out_fire),
        .out_item    (out_item),
        .sched_valid (sched_valid),
        .sched_ready (sched_ready),
        .sched_item  (sched_item)
    );

endmodule

// File: design/issue_stage.sv
// fixed priority to the lowest wid, so a busy low warp can starve higher ones
`timescale 1ns/1ps

module issue_stage import warp_sched_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  warp_mask_t             ready_warps,
    input  tmask_t [num_warps-1:0] warp_tmasks,
    input  pc_t [num_warps-1:0]    warp_pcs,
    output logic                   select_fire,
    output wid_t                   select_wid,
    output logic                   out_fire,
    output sched_item_t            out_item,
    output logic                   sched_valid,
    input  logic                   sched_ready,
    output sched_item_t            sched_item
);

    logic        pick_valid;
    wid_t        pick_wid;
    sched_item_t pick_item;

    // head drives the outputs, tail catches one item under back-pressure
    sched_item_t head_q;
    sched_item_t tail_q;
    logic        head_valid;
    logic        tail_valid;
    logic        head_load;

    always_comb begin
        pick_valid = 1'b0;
        pick_wid   = '0;
        for (int i = num_warps - 1; i >= 0; i--) begin
            if (ready_warps[i]) begin
                pick_valid = 1'b1;
                pick_wid   = wid_t'(i);
            end
        end
    end

    assign pick_item.wid   = pick_wid;
    assign pick_item.tmask = warp_tmasks[pick_wid];
    assign pick_item.pc    = warp_pcs[pick_wid];

    // room while the buffer holds fewer than two
    assign select_fire = pick_valid && !tail_valid;
    assign select_wid  = pick_wid;

    assign out_fire  = head_valid && sched_ready;
    assign head_load = !head_valid || out_fire;

    always_ff @(posedge clk) begin
        if (reset) begin
            head_valid <= 1'b0;
            tail_valid <= 1'b0;
        end else if (head_load) begin
            head_valid <= tail_valid || select_fire;
            tail_valid <= 1'b0;
        end else if (select_fire) begin
            tail_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (head_load) begin
            head_q <= tail_valid ? tail_q : pick_item;
        end
        if (!head_load && select_fire) begin
            tail_q <= pick_item;
        end
    end

    assign out_item    = head_q;
    assign sched_valid = head_valid;
    assign sched_item  = head_q;

endmodule

// File: design/barrier_unit.sv
// local barriers only; generations are 8 bits and compared wrap-safe, so tokens must stay within 127
`timescale 1ns/1ps

module barrier_unit import warp_sched_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       warp_ctl_valid,
    input  warp_ctl_t  warp_ctl,
    input  bar_id_t    bar_rd_id,
    output gen_t       arrive_token,
    output warp_mask_t bar_release
);

    gen_t [num_barriers-1:0]       gen_q, gen_n;
    wid_t [num_barriers-1:0]       count_q, count_n;
    warp_mask_t [num_barriers-1:0] waiting_q, waiting_n;

    barrier_t bar;
    logic     bar_fire;
    logic     last_arrival;
    gen_t     gen_diff;

    assign bar      = warp_ctl.barrier;
    assign bar_fire = warp_ctl_valid && bar.bar_valid;

    // generation minus token, read as signed
    assign gen_diff = gen_q[bar.id] - bar.token;

    always_comb begin
        gen_n        = gen_q;
        count_n      = count_q;
        waiting_n    = waiting_q;
        bar_release  = '0;
        last_arrival = 1'b0;

        if (bar_fire) begin
            case (bar.op)
                bar_arrive: begin
                    if (count_q[bar.id] == bar.count) begin
                        // barrier complete, wake everyone parked on it
                        last_arrival     = 1'b1;
                        count_n[bar.id]   = '0;
                        gen_n[bar.id]     = gen_q[bar.id] + gen_t'(1);
                        bar_release       = waiting_q[bar.id];
                        waiting_n[bar.id] = '0;
                    end else begin
                        count_n[bar.id] = count_q[bar.id] + wid_t'(1);
                    end

                    // sync arrive blocks unless it closed the barrier
                    if (!bar.is_sync || last_arrival) begin
                        bar_release[warp_ctl.wid] = 1'b1;
                    end else begin
                        waiting_n[bar.id][warp_ctl.wid] = 1'b1;
                    end
                end
                bar_wait: begin
                    if (!gen_diff[gen_bits-1] && (gen_diff != '0)) begin
                        bar_release[warp_ctl.wid] = 1'b1;
                    end else begin
                        waiting_n[bar.id][warp_ctl.wid] = 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            gen_q     <= '0;
            count_q   <= '0;
            waiting_q <= '0;
        end else begin
            gen_q     <= gen_n;
            count_q   <= count_n;
            waiting_q <= waiting_n;
        end
    end

    assign arrive_token = gen_q[bar_rd_id];

endmodule

// File: design/warp_table.sv
// per-warp state; expects at most one tmc/spawn/barrier op per warp_ctl strobe and one spawn pending
`timescale 1ns/1ps

module warp_table import warp_sched_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  pc_t                          startup_pc,
    input  logic                         warp_ctl_valid,
    input  warp_ctl_t                    warp_ctl,
    input  logic                         branch_valid,
    input  branch_t                      branch,
    input  logic                         unlock_valid,
    input  wid_t                         unlock_wid,
    input  warp_mask_t                   bar_release,
    input  logic                         select_fire,
    input  wid_t                         select_wid,
    input  logic                         out_fire,
    input  sched_item_t                  out_item,
    output warp_mask_t                   ready_warps,
    output tmask_t [num_warps-1:0]       warp_tmasks,
    output pc_t [num_warps-1:0]          warp_pcs,
    output logic                         busy
);

    warp_mask_t             active_q, active_n;
    warp_mask_t             stalled_q, stalled_n;
    tmask_t [num_warps-1:0] tmasks_q, tmasks_n;
    pc_t [num_warps-1:0]    pcs_q, pcs_n;

    // deferred spawn, held until a single warp is left running
    wspawn_t spawn_q;
    wid_t    spawn_wid_q;
    wspawn_t spawn_req;
    wid_t    spawn_req_wid;
    logic    spawn_new;
    logic    spawn_apply;
    logic    single_warp;
    logic    tmc_fire;
    logic    branch_same_warp;

    assign spawn_new     = warp_ctl_valid && warp_ctl.wspawn.spawn_valid;
    assign spawn_req     = spawn_new ? warp_ctl.wspawn : spawn_q;
    assign spawn_req_wid = spawn_new ? warp_ctl.wid : spawn_wid_q;

    // exactly one bit set in the active mask
    assign single_warp = (active_q != '0)
                      && ((active_q & (active_q - warp_mask_t'(1))) == '0);
    assign spawn_apply = spawn_req.spawn_valid && single_warp;

    assign tmc_fire = warp_ctl_valid && warp_ctl.tmc.tmc_valid;

    // a taken branch overrides the pc+4 of an item leaving in the same cycle
    assign branch_same_warp = branch_valid && branch.taken && (branch.wid == out_item.wid);

    always_comb begin
        active_n  = active_q;
        stalled_n = stalled_q;
        tmasks_n  = tmasks_q;
        pcs_n     = pcs_q;

        if (unlock_valid) begin
            stalled_n[unlock_wid] = 1'b0;
        end

        if (spawn_apply) begin
            for (int i = 0; i < num_warps; i++) begin
                if (spawn_req.wmask[i]) begin
                    active_n[i]  = 1'b1;
                    stalled_n[i] = 1'b0;
                    tmasks_n[i]  = tmask_t'(1);
                    pcs_n[i]     = spawn_req.pc;
                end
            end
            stalled_n[spawn_req_wid] = 1'b0;
        end

        // an empty mask retires the warp
        if (tmc_fire) begin
            active_n[warp_ctl.wid]  = (warp_ctl.tmc.tmask != '0);
            tmasks_n[warp_ctl.wid]  = warp_ctl.tmc.tmask;
            stalled_n[warp_ctl.wid] = 1'b0;
        end

        stalled_n = stalled_n & ~bar_release;

        if (branch_valid) begin
            if (branch.taken) begin
                pcs_n[branch.wid] = branch.dest;
            end
            stalled_n[branch.wid] = 1'b0;
        end

        // hold the warp until decode, branch or barrier lets it go
        if (select_fire) begin
            stalled_n[select_wid] = 1'b1;
        end

        if (out_fire && !branch_same_warp) begin
            pcs_n[out_item.wid] = out_item.pc + pc_t'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active_q    <= warp_mask_t'(1);
            stalled_q   <= '0;
            tmasks_q    <= '0;
            tmasks_q[0] <= tmask_t'(1);
            pcs_q       <= '0;
            pcs_q[0]    <= startup_pc;
            busy        <= 1'b1;
        end else begin
            active_q  <= active_n;
            stalled_q <= stalled_n;
            tmasks_q  <= tmasks_n;
            pcs_q     <= pcs_n;
            busy      <= (active_q != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            spawn_q.spawn_valid <= 1'b0;
        end else if (spawn_apply) begin
            spawn_q.spawn_valid <= 1'b0;
        end else if (spawn_new) begin
            spawn_q     <= warp_ctl.wspawn;
            spawn_wid_q <= warp_ctl.wid;
        end
    end

    assign ready_warps = active_q & ~stalled_q;
    assign warp_tmasks = tmasks_q;
    assign warp_pcs    = pcs_q;

endmodule

// File: design/warp_sched_pkg.sv
// shared types for a 4-warp, 4-thread scheduler; widths are fixed here and no module overrides them
package warp_sched_pkg;

    localparam int num_warps    = 4;
    localparam int num_threads  = 4;
    localparam int num_barriers = 4;
    localparam int pc_bits      = 32;
    localparam int gen_bits     = 8;

    typedef logic [1:0]               wid_t;
    typedef logic [num_warps-1:0]     warp_mask_t;
    typedef logic [num_threads-1:0]   tmask_t;
    typedef logic [pc_bits-1:0]       pc_t;
    typedef logic [1:0]               bar_id_t;
    typedef logic [gen_bits-1:0]      gen_t;

    typedef enum logic {
        bar_arrive = 1'b0,
        bar_wait   = 1'b1
    } bar_op_e;

    typedef struct packed {
        logic   tmc_valid;
        tmask_t tmask;
    } tmc_t;

    typedef struct packed {
        logic       spawn_valid;
        warp_mask_t wmask;
        pc_t        pc;
    } wspawn_t;

    // count holds the expected number of warps minus one
    typedef struct packed {
        logic    bar_valid;
        bar_op_e op;
        logic    is_sync;
        bar_id_t id;
        wid_t    count;
        gen_t    token;
    } barrier_t;

    typedef struct packed {
        wid_t     wid;
        tmc_t     tmc;
        wspawn_t  wspawn;
        barrier_t barrier;
    } warp_ctl_t;

    typedef struct packed {
        wid_t wid;
        logic taken;
        pc_t  dest;
    } branch_t;

    typedef struct packed {
        wid_t   wid;
        tmask_t tmask;
        pc_t    pc;
    } sched_item_t;

endpackage
